// File: common/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIndexT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOpT;

    typedef enum logic [1:0] {
        pcSequential,
        pcBranch,
        pcJump
    } pcSrcT;

    typedef enum logic [1:0] {
        fwdRegister,
        fwdMemory,
        fwdWriteback
    } fwdSelT;

    // Primary opcodes, instruction[31:26]
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri   = 6'h0D;
    localparam logic [5:0] opLui   = 6'h0F;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2B;

    // R-type function codes, instruction[5:0]
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2A;

    // All-zero payloads are bubbles
    typedef struct packed {
        wordT instruction;
        wordT pcPlus4;
    } ifIdT;

    typedef struct packed {
        wordT     operandA;
        wordT     operandB;
        wordT     immediate;
        regIndexT rs;
        regIndexT rt;
        regIndexT dest;
        aluOpT    aluOperation;
        logic     useImmediate;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
    } idExT;

    typedef struct packed {
        wordT     aluResult;
        wordT     storeData;
        regIndexT dest;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
    } exMemT;

    typedef struct packed {
        wordT     result;
        regIndexT dest;
        logic     regWrite;
    } memWbT;

endpackage

// File: hdl/stageRegister.sv
module stageRegister #(
    parameter type payloadT = logic
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    hold,
    input  payloadT inData,
    output payloadT outData
);

    always_ff @(posedge clock) begin
        if (reset) begin
            outData <= '0;              // Bubble
        end else if (!hold) begin
            outData <= inData;
        end
    end

endmodule

// File: hdl/registerFile.sv
module registerFile import mipsPkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  regIndexT readIndexA,
    input  regIndexT readIndexB,
    output wordT     readDataA,
    output wordT     readDataB,
    input  regIndexT writeIndex,
    input  wordT     writeData,
    input  logic     writeEnable
);

    wordT registers [1:31];             // $zero has no storage

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && writeIndex != '0) begin
            registers[writeIndex] <= writeData;
        end
    end

    // A read of the register being written sees the new value
    assign readDataA = (readIndexA == '0) ? '0 :
                       (writeEnable && writeIndex == readIndexA) ? writeData :
                       registers[readIndexA];
    assign readDataB = (readIndexB == '0) ? '0 :
                       (writeEnable && writeIndex == readIndexB) ? writeData :
                       registers[readIndexB];

endmodule

// File: hdl/alu.sv
module alu import mipsPkg::*; (
    input  aluOpT operation,
    input  wordT  operandA,
    input  wordT  operandB,
    output wordT  result
);

    // Overflow is not detected, ADDU and ADDIU wrap
    always_comb begin
        case (operation)
            aluAdd: begin
                result = operandA + operandB;
            end
            aluSub: begin
                result = operandA - operandB;
            end
            aluAnd: begin
                result = operandA & operandB;
            end
            aluOr: begin
                result = operandA | operandB;
            end
            aluSlt: begin
                result = {31'b0, $signed(operandA) < $signed(operandB)};
            end
            aluLui: begin
                result = {operandB[15:0], 16'b0};     // Immediate into the upper half
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: control/decodeControl.sv
module decodeControl import mipsPkg::*; (
    input  wordT  instruction,
    input  logic  operandsEqual,
    output pcSrcT pcSource,
    output aluOpT aluOperation,
    output logic  useImmediate,
    output logic  signExtend,
    output logic  writeToRt,
    output logic  regWrite,
    output logic  memRead,
    output logic  memWrite,
    output logic  readsRs,
    output logic  readsRt
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instruction[31:26];
    assign funct  = instruction[5:0];

    always_comb begin
        pcSource     = pcSequential;    // No-op unless decoded below
        aluOperation = aluAdd;
        useImmediate = 1'b0;
        signExtend   = 1'b0;
        writeToRt    = 1'b0;
        regWrite     = 1'b0;
        memRead      = 1'b0;
        memWrite     = 1'b0;
        readsRs      = 1'b0;
        readsRt      = 1'b0;

        case (opcode)
            opRType: begin
                readsRs  = 1'b1;
                readsRt  = 1'b1;
                regWrite = 1'b1;
                case (funct)
                    fnAddu: aluOperation = aluAdd;
                    fnSubu: aluOperation = aluSub;
                    fnAnd:  aluOperation = aluAnd;
                    fnOr:   aluOperation = aluOr;
                    fnSlt:  aluOperation = aluSlt;
                    default: begin
                        readsRs  = 1'b0;   // Unknown function, also SLL $0 from reset
                        readsRt  = 1'b0;
                        regWrite = 1'b0;
                    end
                endcase
            end
            opAddiu, opLw: begin
                aluOperation = aluAdd;
                useImmediate = 1'b1;
                signExtend   = 1'b1;
                writeToRt    = 1'b1;
                regWrite     = 1'b1;
                readsRs      = 1'b1;
                memRead      = (opcode == opLw);
            end
            opOri: begin
                aluOperation = aluOr;
                useImmediate = 1'b1;    // Zero-extended
                writeToRt    = 1'b1;
                regWrite     = 1'b1;
                readsRs      = 1'b1;
            end
            opLui: begin
                aluOperation = aluLui;
                useImmediate = 1'b1;
                writeToRt    = 1'b1;
                regWrite     = 1'b1;
            end
            opSw: begin
                aluOperation = aluAdd;
                useImmediate = 1'b1;
                signExtend   = 1'b1;
                memWrite     = 1'b1;
                readsRs      = 1'b1;
                readsRt      = 1'b1;    // Store data
            end
            opBeq, opBne: begin
                signExtend = 1'b1;      // Branch offset
                readsRs    = 1'b1;
                readsRt    = 1'b1;
                if (operandsEqual == (opcode == opBeq)) begin
                    pcSource = pcBranch;
                end
            end
            opJ: begin
                pcSource = pcJump;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: control/hazardUnit.sv
module hazardUnit import mipsPkg::*; (
    input  regIndexT idRs,
    input  regIndexT idRt,
    input  logic     idReadsRs,
    input  logic     idReadsRt,
    input  logic     idIsBranch,
    input  regIndexT exRs,
    input  regIndexT exRt,
    input  regIndexT exDest,
    input  logic     exRegWrite,
    input  logic     exMemRead,
    input  regIndexT memDest,
    input  logic     memRegWrite,
    input  logic     memMemRead,
    input  regIndexT wbDest,
    input  logic     wbRegWrite,
    output logic     idCompareFwdA,
    output logic     idCompareFwdB,
    output fwdSelT   exFwdA,
    output fwdSelT   exFwdB,
    output logic     frontStall
);

    logic exFeedsId;
    logic memFeedsId;

    // True when a stage writes the given source register, $zero never matches
    function automatic logic produces(logic writes, regIndexT dest, regIndexT source);
        return writes && dest != '0 && dest == source;
    endfunction

    // MEM is younger than WB, so it wins
    assign exFwdA = produces(memRegWrite, memDest, exRs) ? fwdMemory :
                    produces(wbRegWrite, wbDest, exRs)   ? fwdWriteback : fwdRegister;
    assign exFwdB = produces(memRegWrite, memDest, exRt) ? fwdMemory :
                    produces(wbRegWrite, wbDest, exRt)   ? fwdWriteback : fwdRegister;

    // WB results reach decode through the register file bypass
    assign idCompareFwdA = produces(memRegWrite, memDest, idRs);
    assign idCompareFwdB = produces(memRegWrite, memDest, idRt);

    assign exFeedsId  = (idReadsRs && produces(exRegWrite, exDest, idRs)) ||
                        (idReadsRt && produces(exRegWrite, exDest, idRt));
    assign memFeedsId = (idReadsRs && produces(memRegWrite, memDest, idRs)) ||
                        (idReadsRt && produces(memRegWrite, memDest, idRt));

    // Load-use, or a branch whose compare value is not ready yet
    assign frontStall = (exFeedsId && (exMemRead || idIsBranch)) ||
                        (memFeedsId && memMemRead && idIsBranch);

endmodule

// File: hdl/mipsCore.sv
module mipsCore import mipsPkg::*; #(
    parameter wordT ResetVector = '0
) (
    input  logic clock,
    input  logic reset,
    output wordT instAddress,
    input  wordT instruction,
    output wordT dataAddress,
    output wordT dataWriteData,
    output logic dataRead,
    output logic dataWrite,
    input  wordT dataIn,
    input  logic dataStall
);

    wordT     pc;
    wordT     pcPlus4;
    wordT     nextPc;
    wordT     branchTarget;
    wordT     jumpTarget;
    logic     frontHold;
    ifIdT     ifIdIn;
    ifIdT     ifId;
    idExT     idExIn;
    idExT     idEx;
    exMemT    exMemIn;
    exMemT    exMem;
    memWbT    memWbIn;
    memWbT    memWb;
    regIndexT rs;
    regIndexT rt;
    regIndexT rd;
    wordT     immediate;
    wordT     readDataA;
    wordT     readDataB;
    wordT     compareA;
    wordT     compareB;
    logic     operandsEqual;
    logic     isBranch;
    pcSrcT    pcSource;
    aluOpT    aluOperation;
    logic     useImmediate;
    logic     signExtend;
    logic     writeToRt;
    logic     regWrite;
    logic     memRead;
    logic     memWrite;
    logic     readsRs;
    logic     readsRt;
    logic     idCompareFwdA;
    logic     idCompareFwdB;
    fwdSelT   exFwdA;
    fwdSelT   exFwdB;
    logic     frontStall;
    wordT     exOperandA;
    wordT     exOperandB;
    wordT     aluInputB;
    wordT     aluResult;

    function automatic wordT forwardOperand(fwdSelT sel, wordT regValue, wordT memValue,
                                            wordT wbValue);
        case (sel)
            fwdMemory:    return memValue;
            fwdWriteback: return wbValue;
            default:      return regValue;
        endcase
    endfunction

    // Fetch
    assign frontHold = dataStall || frontStall;
    assign pcPlus4   = pc + 32'd4;
    assign nextPc    = (pcSource == pcBranch) ? branchTarget :
                       (pcSource == pcJump)   ? jumpTarget : pcPlus4;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= ResetVector;
        end else if (!frontHold) begin
            pc <= nextPc;
        end
    end

    assign instAddress = pc;
    assign ifIdIn      = '{instruction: instruction, pcPlus4: pcPlus4};

    stageRegister #(.payloadT(ifIdT)) i_ifId (
        .clock   (clock),
        .reset   (reset),
        .hold    (frontHold),
        .inData  (ifIdIn),
        .outData (ifId)
    );

    // Decode
    assign rs = ifId.instruction[25:21];
    assign rt = ifId.instruction[20:16];
    assign rd = ifId.instruction[15:11];
    assign immediate = signExtend ? {{16{ifId.instruction[15]}}, ifId.instruction[15:0]}
                                  : {16'b0, ifId.instruction[15:0]};
    assign branchTarget = ifId.pcPlus4 + {immediate[29:0], 2'b00};
    assign jumpTarget   = {ifId.pcPlus4[31:28], ifId.instruction[25:0], 2'b00};
    assign isBranch     = ifId.instruction[31:26] == opBeq || ifId.instruction[31:26] == opBne;

    registerFile i_registerFile (
        .clock       (clock),
        .reset       (reset),
        .readIndexA  (rs),
        .readIndexB  (rt),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .writeIndex  (memWb.dest),
        .writeData   (memWb.result),
        .writeEnable (memWb.regWrite)
    );

    assign compareA      = idCompareFwdA ? exMem.aluResult : readDataA;
    assign compareB      = idCompareFwdB ? exMem.aluResult : readDataB;
    assign operandsEqual = compareA == compareB;

    decodeControl i_decodeControl (
        .instruction   (ifId.instruction),
        .operandsEqual (operandsEqual),
        .pcSource      (pcSource),
        .aluOperation  (aluOperation),
        .useImmediate  (useImmediate),
        .signExtend    (signExtend),
        .writeToRt     (writeToRt),
        .regWrite      (regWrite),
        .memRead       (memRead),
        .memWrite      (memWrite),
        .readsRs       (readsRs),
        .readsRt       (readsRt)
    );

    hazardUnit i_hazardUnit (
        .idRs          (rs),
        .idRt          (rt),
        .idReadsRs     (readsRs),
        .idReadsRt     (readsRt),
        .idIsBranch    (isBranch),
        .exRs          (idEx.rs),
        .exRt          (idEx.rt),
        .exDest        (idEx.dest),
        .exRegWrite    (idEx.regWrite),
        .exMemRead     (idEx.memRead),
        .memDest       (exMem.dest),
        .memRegWrite   (exMem.regWrite),
        .memMemRead    (exMem.memRead),
        .wbDest        (memWb.dest),
        .wbRegWrite    (memWb.regWrite),
        .idCompareFwdA (idCompareFwdA),
        .idCompareFwdB (idCompareFwdB),
        .exFwdA        (exFwdA),
        .exFwdB        (exFwdB),
        .frontStall    (frontStall)
    );

    // Late producers are picked up again by the execute forwarding
    always_comb begin
        idExIn = '0;                    // Bubble while decode waits
        if (!frontStall) begin
            idExIn.operandA     = readDataA;
            idExIn.operandB     = readDataB;
            idExIn.immediate    = immediate;
            idExIn.rs           = rs;
            idExIn.rt           = rt;
            idExIn.dest         = writeToRt ? rt : rd;
            idExIn.aluOperation = aluOperation;
            idExIn.useImmediate = useImmediate;
            idExIn.regWrite     = regWrite;
            idExIn.memRead      = memRead;
            idExIn.memWrite     = memWrite;
        end
    end

    stageRegister #(.payloadT(idExT)) i_idEx (
        .clock   (clock),
        .reset   (reset),
        .hold    (dataStall),
        .inData  (idExIn),
        .outData (idEx)
    );

    // Execute
    assign exOperandA = forwardOperand(exFwdA, idEx.operandA, exMem.aluResult, memWb.result);
    assign exOperandB = forwardOperand(exFwdB, idEx.operandB, exMem.aluResult, memWb.result);
    assign aluInputB  = idEx.useImmediate ? idEx.immediate : exOperandB;

    alu i_alu (
        .operation (idEx.aluOperation),
        .operandA  (exOperandA),
        .operandB  (aluInputB),
        .result    (aluResult)
    );

    assign exMemIn = '{aluResult: aluResult, storeData: exOperandB, dest: idEx.dest,
                       regWrite: idEx.regWrite, memRead: idEx.memRead,
                       memWrite: idEx.memWrite};

    stageRegister #(.payloadT(exMemT)) i_exMem (
        .clock   (clock),
        .reset   (reset),
        .hold    (dataStall),
        .inData  (exMemIn),
        .outData (exMem)
    );

    // Memory
    assign dataAddress   = exMem.aluResult;
    assign dataWriteData = exMem.storeData;
    assign dataRead      = exMem.memRead;
    assign dataWrite     = exMem.memWrite;

    assign memWbIn = '{result: exMem.memRead ? dataIn : exMem.aluResult,
                       dest: exMem.dest, regWrite: exMem.regWrite};

    stageRegister #(.payloadT(memWbT)) i_memWb (
        .clock   (clock),
        .reset   (reset),
        .hold    (dataStall),       // Load data is taken on the edge the stall ends
        .inData  (memWbIn),
        .outData (memWb)
    );

endmodule

// File: dv/storeChecker.sv
module storeChecker import mipsPkg::*; #(
    parameter wordT ResetVector = '0
) (
    input  logic clock,
    input  logic reset,
    input  wordT programMemory [64],
    input  wordT dataMemory [64],
    input  wordT instAddress,
    input  wordT dataAddress,
    input  wordT dataWriteData,
    input  logic dataRead,
    input  logic dataWrite,
    input  logic dataStall,
    output int   errorCount,
    output int   storeCount,
    output int   expectedCount,
    output int   referenceSteps
);

    wordT expectedAddress [$];
    wordT expectedData [$];
    int   errors = 0;
    int   stores = 0;
    logic resetSeen = 1'b0;
    logic firstCycleSeen = 1'b0;
    logic lastStall = 1'b0;
    logic lastRead;
    logic lastWrite;
    wordT lastAddress;
    wordT lastData;

    assign errorCount = errors;
    assign storeCount = stores;

    // ISA-level run of the program, delay slots included, collecting stores
    function automatic int runReference();
        wordT     regs [32];
        wordT     mem [64];
        wordT     pc;
        wordT     nextPc;
        wordT     target;
        wordT     inst;
        wordT     imm;
        wordT     addr;
        regIndexT rs;
        regIndexT rt;
        regIndexT rd;
        int       steps;
        logic     halted;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = dataMemory[i];
        end
        pc     = ResetVector;
        nextPc = ResetVector + 32'd4;
        steps  = 0;
        halted = 1'b0;
        while (!halted && steps < 1000) begin
            inst   = programMemory[pc[7:2]];
            rs     = inst[25:21];
            rt     = inst[20:16];
            rd     = inst[15:11];
            imm    = {{16{inst[15]}}, inst[15:0]};
            addr   = regs[rs] + imm;
            target = nextPc + 32'd4;
            case (inst[31:26])
                opRType: begin
                    case (inst[5:0])
                        fnAddu: regs[rd] = regs[rs] + regs[rt];
                        fnSubu: regs[rd] = regs[rs] - regs[rt];
                        fnAnd:  regs[rd] = regs[rs] & regs[rt];
                        fnOr:   regs[rd] = regs[rs] | regs[rt];
                        fnSlt:  regs[rd] = ($signed(regs[rs]) < $signed(regs[rt])) ? 32'd1 : '0;
                        default: ;
                    endcase
                end
                opAddiu: regs[rt] = regs[rs] + imm;
                opOri:   regs[rt] = regs[rs] | {16'b0, inst[15:0]};
                opLui:   regs[rt] = {inst[15:0], 16'b0};
                opLw:    regs[rt] = mem[addr[7:2]];
                opSw: begin
                    mem[addr[7:2]] = regs[rt];
                    expectedAddress.push_back(addr);
                    expectedData.push_back(regs[rt]);
                end
                opBeq: begin
                    if (regs[rs] == regs[rt]) target = pc + 32'd4 + (imm << 2);
                end
                opBne: begin
                    if (regs[rs] != regs[rt]) target = pc + 32'd4 + (imm << 2);
                end
                opJ: begin
                    target = {nextPc[31:28], inst[25:0], 2'b00};   // Region of the delay slot
                    halted = (target == pc);    // Jump to itself ends the program
                end
                default: ;
            endcase
            regs[0] = '0;
            pc      = nextPc;
            nextPc  = target;
            steps++;
        end
        return steps;
    endfunction

    task automatic reportFailure(input string message);
        $display("[FAIL] %0t %s", $time, message);
        errors++;
    endtask

    initial begin
        @(posedge clock);               // Program and data are built at time zero
        referenceSteps = runReference();
        expectedCount  = expectedAddress.size();
    end

    always @(posedge clock) begin
        if (reset) begin
            if (resetSeen && (dataRead !== 1'b0 || dataWrite !== 1'b0)) begin
                reportFailure("memory access requested during reset");
            end
            resetSeen      <= 1'b1;
            firstCycleSeen <= 1'b0;
        end else begin
            if (!firstCycleSeen) begin
                if (instAddress !== ResetVector) begin
                    reportFailure($sformatf("first fetch at %h, expected %h",
                                            instAddress, ResetVector));
                end
                if (dataRead !== 1'b0 || dataWrite !== 1'b0) begin
                    reportFailure("memory access in the cycle after reset");
                end
                firstCycleSeen <= 1'b1;
            end
            if (lastStall && (dataRead !== lastRead || dataWrite !== lastWrite ||
                              dataAddress !== lastAddress ||
                              dataWriteData !== lastData)) begin
                reportFailure("data bus changed while stalled");
            end
            if (dataWrite === 1'b1 && dataStall === 1'b0) begin
                if (stores >= expectedCount) begin
                    $display("Store count wrong: store %0d completed, only %0d expected",
                             stores + 1, expectedCount);
                    errors++;
                end else if (dataAddress !== expectedAddress[stores] ||
                             dataWriteData !== expectedData[stores]) begin
                    reportFailure($sformatf("store %0d wrote %h to %h, expected %h to %h",
                                            stores, dataWriteData, dataAddress,
                                            expectedData[stores], expectedAddress[stores]));
                end
                stores++;
            end
        end
        lastStall   <= dataStall && !reset;
        lastRead    <= dataRead;
        lastWrite   <= dataWrite;
        lastAddress <= dataAddress;
        lastData    <= dataWriteData;
    end

endmodule

// File: dv/mipsCoreTb.sv
module mipsCoreTb import mipsPkg::*; ();

    localparam wordT startAddress = 32'h0000_0100;

    logic clock;
    logic reset;
    wordT instAddress;
    wordT instruction;
    wordT dataAddress;
    wordT dataWriteData;
    wordT dataIn;
    logic dataRead;
    logic dataWrite;
    logic dataStall = 1'b0;
    wordT programMemory [64];
    wordT dataMemory [64];
    int   seed;
    int   fillIndex;
    int   stallLeft = 0;
    int   stallCycles;
    int   cycleCount = 0;
    int   cycleLimit;
    logic timedOut;
    int   errorCount;
    int   storeCount;
    int   expectedCount;
    int   referenceSteps;

    always #4 clock = ~clock;

    assign instruction = programMemory[instAddress[7:2]];   // Same-cycle fetch
    assign dataIn      = dataMemory[dataAddress[7:2]];

    function automatic wordT rTypeWord(regIndexT rs, regIndexT rt, regIndexT rd,
                                       logic [5:0] fn);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT immWord(logic [5:0] op, regIndexT rs, regIndexT rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jumpWord(int index);
        wordT target;
        target = startAddress + index * 4;
        return {opJ, target[27:2]};
    endfunction

    // Distinct registers in 8..23 for k = 0..7
    function automatic regIndexT pickRegister(int base, int k);
        return regIndexT'(8 + (base + 3 * k) % 16);
    endfunction

    task automatic place(input wordT word);
        programMemory[fillIndex] = word;
        fillIndex++;
    endtask

    task automatic addAluChain();
        int       base;
        regIndexT a;
        regIndexT b;
        regIndexT c;
        regIndexT d;
        regIndexT e;
        base = $unsigned($random(seed)) % 16;
        a = pickRegister(base, 0);
        b = pickRegister(base, 1);
        c = pickRegister(base, 2);
        d = pickRegister(base, 3);
        e = pickRegister(base, 4);
        place(immWord(opLui, 5'd0, a, 16'($random(seed))));
        place(immWord(opOri, a, a, 16'($random(seed))));
        place(immWord(opAddiu, a, b, 16'($random(seed))));
        place(rTypeWord(a, b, c, fnAddu));
        place(rTypeWord(c, a, d, fnSubu));
        place(immWord(opSw, 5'd0, d, 16'h0080));    // Store data from MEM
        place(rTypeWord(c, d, e, fnAnd));
        place(rTypeWord(e, b, e, fnOr));
        place(immWord(opSw, 5'd0, e, 16'h0084));
        place(rTypeWord(b, a, d, fnSlt));
        place(immWord(opSw, 5'd0, c, 16'h0088));
        place(immWord(opSw, 5'd0, d, 16'h008C));
    endtask

    task automatic addLoadUse();
        int       base;
        regIndexT a;
        regIndexT b;
        regIndexT c;
        base = $unsigned($random(seed)) % 16;
        a = pickRegister(base, 0);
        b = pickRegister(base, 1);
        c = pickRegister(base, 2);
        place(immWord(opLw, 5'd0, a, 16'(($unsigned($random(seed)) % 32) * 4)));
        place(rTypeWord(a, a, b, fnAddu));
        place(immWord(opSw, 5'd0, b, 16'h0090));
        place(immWord(opLw, 5'd0, c, 16'h0084));    // Reads back an earlier store
        place(immWord(opSw, 5'd0, c, 16'h0094));
    endtask

    task automatic addBranchLoop();
        int       base;
        int       loopStart;
        regIndexT a;
        regIndexT b;
        regIndexT c;
        regIndexT p;
        base = $unsigned($random(seed)) % 16;
        a = pickRegister(base, 0);
        b = pickRegister(base, 1);
        c = pickRegister(base, 2);
        p = pickRegister(base, 3);
        place(immWord(opAddiu, 5'd0, a, 16'(2 + $unsigned($random(seed)) % 3)));
        place(immWord(opAddiu, 5'd0, b, 16'h0000));
        place(immWord(opAddiu, 5'd0, p, 16'h0000));
        loopStart = fillIndex;
        place(immWord(opAddiu, p, p, 16'h0004));
        place(immWord(opAddiu, b, b, 16'($random(seed))));
        place(immWord(opAddiu, a, a, 16'hFFFF));
        place(immWord(opBne, a, 5'd0, 16'(loopStart - (fillIndex + 1))));
        place(immWord(opSw, p, b, 16'h009C));       // Delay slot, runs every pass
        place(immWord(opLw, p, c, 16'h009C));       // Reloads the last loop store
        place(immWord(opBeq, c, b, 16'h0002));      // Waits for the load in EX and MEM
        place(immWord(opSw, 5'd0, b, 16'h00B0));
        place(immWord(opSw, 5'd0, c, 16'h00B4));
        place(immWord(opSw, 5'd0, a, 16'h00B8));
    endtask

    task automatic addJumpOver();
        int       base;
        regIndexT a;
        regIndexT b;
        base = $unsigned($random(seed)) % 16;
        a = pickRegister(base, 0);
        b = pickRegister(base, 5);
        place(jumpWord(fillIndex + 4));
        place(immWord(opSw, 5'd0, a, 16'h00C0));
        place(immWord(opSw, 5'd0, a, 16'h00C4));
        place(immWord(opSw, 5'd0, a, 16'h00C8));
        place(immWord(opSw, 5'd0, b, 16'h00CC));
        place(jumpWord(fillIndex));                 // Spin here once done
        place('0);
    endtask

    mipsCore #(
        .ResetVector (startAddress)
    ) i_mipsCore (
        .clock         (clock),
        .reset         (reset),
        .instAddress   (instAddress),
        .instruction   (instruction),
        .dataAddress   (dataAddress),
        .dataWriteData (dataWriteData),
        .dataRead      (dataRead),
        .dataWrite     (dataWrite),
        .dataIn        (dataIn),
        .dataStall     (dataStall)
    );

    storeChecker #(
        .ResetVector (startAddress)
    ) i_storeChecker (
        .clock          (clock),
        .reset          (reset),
        .programMemory  (programMemory),
        .dataMemory     (dataMemory),
        .instAddress    (instAddress),
        .dataAddress    (dataAddress),
        .dataWriteData  (dataWriteData),
        .dataRead       (dataRead),
        .dataWrite      (dataWrite),
        .dataStall      (dataStall),
        .errorCount     (errorCount),
        .storeCount     (storeCount),
        .expectedCount  (expectedCount),
        .referenceSteps (referenceSteps)
    );

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (dataWrite === 1'b1 && dataStall === 1'b0) begin
            dataMemory[dataAddress[7:2]] <= dataWriteData;
        end
    end

    // Stall length is drawn as an access moves from EX into MEM
    always @(posedge clock) begin
        if (reset) begin
            dataStall <= 1'b0;
            stallLeft <= 0;
        end else if (dataStall) begin
            if (stallLeft == 0) begin
                dataStall <= 1'b0;
            end else begin
                stallLeft <= stallLeft - 1;
            end
        end else if (i_mipsCore.idEx.memRead || i_mipsCore.idEx.memWrite) begin
            stallCycles = $unsigned($random(seed)) % 4;
            dataStall <= stallCycles != 0;
            stallLeft <= (stallCycles == 0) ? 0 : stallCycles - 1;
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        seed  = 73;
        for (int i = 0; i < 64; i++) begin
            programMemory[i] = '0;
            dataMemory[i]    = (i * 32'h9E37_79B1) ^ 32'h5A00_00A5;
        end
        fillIndex = 0;
        addAluChain();
        addLoadUse();
        addBranchLoop();
        addJumpOver();

        repeat (3) @(posedge clock);
        reset <= 1'b0;
        cycleLimit = 4 * referenceSteps + 100;
        while (!(expectedCount > 0 && storeCount == expectedCount) &&
               cycleCount < cycleLimit) begin
            @(negedge clock);
        end
        timedOut = storeCount != expectedCount;
        if (timedOut) begin
            $display("Timeout after %0d cycles with %0d of %0d stores completed",
                     cycleCount, storeCount, expectedCount);
        end else begin
            repeat (10) @(negedge clock);          // Room for any extra store
        end
        $display("Closing: %0d check errors, %0d timeouts, %0d stores",
                 errorCount, timedOut, storeCount);
        if (errorCount == 0 && !timedOut) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: mipsCore.f
common/mipsPkg.sv
hdl/stageRegister.sv
hdl/registerFile.sv
hdl/alu.sv
control/decodeControl.sv
control/hazardUnit.sv
hdl/mipsCore.sv
dv/storeChecker.sv
dv/mipsCoreTb.sv
